/* Bender.yml */
package:
  name: fv_mem

sources:
  - include_dirs:
      - src
    files:
      - src/fv_pkg.sv
      - src/fv_sram_bank.sv
      - src/fv_bank_cntl.sv
      - src/fv_mem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/fv_mem_asserts.sv
      - verif/fv_mem_tb.sv

/* verilog.f */
+incdir+src
src/fv_pkg.sv
src/fv_sram_bank.sv
src/fv_bank_cntl.sv
src/fv_mem_top.sv
verif/fv_mem_asserts.sv
verif/fv_mem_tb.sv

/* verif/fv_mem_tb.sv */
`timescale 1ns/10ps

`include "fv_defs.svh"

module fv_mem_tb;

    import fv_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_BURSTS  = 20;
    localparam int NUM_STREAMS = 8;
    // Streams of up to 32 lines, bursts and reads of up to 8 lines each, plus margin
    localparam int LIMIT_CYC   = NUM_STREAMS * 40 + NUM_BURSTS * 30 + 1000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic [`ITER_W-1:0]      replay_iter;
    logic                    update_phase;
    logic [`FV_NUM_W-1:0]    fv_num;
    logic                    req_valid;
    logic                    req_rd_wr;
    logic                    req_wr_eos;
    logic [`NODE_ID_W-1:0]   req_node_id;
    fv_req_payload_u         req_payload;
    logic                    sm_vld;
    logic                    sm_sos;
    logic                    sm_eos;
    logic [`LINE_IDX_W-1:0]  sm_addr;
    logic [`FV_WIDTH-1:0]    sm_data;
    logic                    edge_vld;
    logic                    edge_sos;
    logic                    edge_eos;
    logic [`PE_TAG_W-1:0]    edge_pe_tag;
    logic [`FV_WIDTH-1:0]    edge_data;

    logic [`FV_WIDTH-1:0] ref_mem [`SRAM_DEPTH];   // Reference copy of the bank

    fv_mem_top dut (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic run_stream(input logic [`ITER_W-1:0] iter, input logic [`FV_NUM_W-1:0] num);
        int nl;
        int idx;
        nl           = (num + 1) / 2;
        replay_iter  = iter;
        fv_num       = num;
        update_phase = 1'b0;
        for (int n = 0; n < `NODES_PER_ITER; n++) begin
            for (int k = 0; k < nl; k++) begin
                @(negedge clk);
                idx    = (iter * `NODES_PER_ITER + n) * `LINES_PER_NODE + k;
                fv_num = '0;   // Length was captured at the trigger
                assert (sm_vld && !edge_vld && sm_sos == (n == 0 && k == 0)
                        && sm_eos == (n == `NODES_PER_ITER - 1 && k == nl - 1))
                    else report_mismatch("stream strobes wrong");
                assert (sm_addr == n * `LINES_PER_NODE + k && sm_data == ref_mem[idx])
                    else report_mismatch($sformatf("stream line %0d of node %0d", k, n));
            end
        end
        repeat (3) begin
            @(negedge clk);
            assert (!sm_vld && dut.sram_cen)
                else report_mismatch("stream restarted with the same iteration");
        end
        update_phase = 1'b1;
    endtask

    task automatic write_burst(input logic [`NODE_ID_W-1:0] node, input int len);
        for (int k = 0; k < len; k++) begin
            req_valid        = 1'b1;
            req_rd_wr        = 1'b1;
            req_wr_eos       = k == len - 1;
            req_node_id      = node;
            req_payload.data = {$urandom, $urandom};
            ref_mem[node * `LINES_PER_NODE + k] = req_payload.data;
            @(negedge clk);
            assert (!sm_vld && !edge_vld) else report_mismatch("output during write burst");
        end
        req_valid  = 1'b0;
        req_wr_eos = 1'b0;
    endtask

    task automatic edge_read(input logic [`NODE_ID_W-1:0] node, input logic [`PE_TAG_W-1:0] tag,
                             input logic [`FV_NUM_W-1:0] num, input bit inject);
        int nl;
        nl                    = (num + 1) / 2;
        req_valid             = 1'b1;
        req_rd_wr             = 1'b0;
        req_wr_eos            = 1'b0;
        req_node_id           = node;
        req_payload           = '0;
        req_payload.rd.pe_tag = tag;
        req_payload.rd.fv_num = num;
        for (int k = 0; k < nl; k++) begin
            @(negedge clk);
            assert (edge_vld && !sm_vld && edge_sos == (k == 0) && edge_eos == (k == nl - 1))
                else report_mismatch("edge read strobes wrong");
            assert (edge_pe_tag == tag && edge_data == ref_mem[node * `LINES_PER_NODE + k])
                else report_mismatch($sformatf("edge read line %0d of node %0d", k, node));
            // Second read in the middle of the burst that the DUT drops
            req_valid             = inject && k == 0;
            req_node_id           = node + 1'b1;
            req_payload.rd.pe_tag = tag + 1'b1;
            req_payload.rd.fv_num = `MAX_FV_NUM;
        end
        req_valid = 1'b0;
        @(negedge clk);
        assert (!edge_vld && !sm_vld) else report_mismatch("extra output after edge read");
    endtask

    always @(negedge clk) begin
        if (dut.u_cntl.u_asserts.fail_cnt != 0) begin
            $display("A protocol assertion on the controller outputs failed");
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        #(LIMIT_CYC * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [`NODE_ID_W-1:0] node;
        void'($urandom(32'hd96fe0a3));
        reset        = 1'b0;
        replay_iter  = '0;
        update_phase = 1'b1;
        fv_num       = '0;
        req_valid    = 1'b0;
        req_rd_wr    = 1'b0;
        req_wr_eos   = 1'b0;
        req_node_id  = '0;
        req_payload  = '0;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            ref_mem[i]         = {$urandom, $urandom};
            dut.u_sram.mem[i]  = ref_mem[i];
        end
        repeat (4) begin
            @(negedge clk);
            assert (!sm_vld && !edge_vld && dut.sram_cen)
                else report_mismatch("outputs active during reset");
        end
        reset = 1'b1;
        @(negedge clk);
        run_stream(0, 16);
        run_stream(1, 7);
        run_stream(2, 1);
        run_stream(3, $urandom_range(16, 1));
        for (int i = 0; i < NUM_BURSTS; i++) begin
            node = $urandom_range(`NUM_NODES - 1, 0);
            write_burst(node, $urandom_range(`LINES_PER_NODE, 1));
            edge_read(node, $urandom_range(`NUM_EDGE_PE - 1, 0), $urandom_range(16, 1), i % 2);
        end
        repeat (4) begin
            edge_read($urandom_range(`NUM_NODES - 1, 0), $urandom_range(`NUM_EDGE_PE - 1, 0),
                      $urandom_range(16, 1), 1'b0);
        end
        for (int it = 0; it < `NUM_REPLAY_ITER; it++) begin
            run_stream(it, $urandom_range(16, 1));
        end
        if (dut.u_cntl.u_asserts.fail_cnt == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("A protocol assertion on the controller outputs failed");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

/* verif/fv_mem_asserts.sv */
`timescale 1ns/10ps

module fv_mem_asserts (
    input logic clk,
    input logic reset,
    input logic sm_vld,
    input logic sm_sos,
    input logic sm_eos,
    input logic edge_vld,
    input logic edge_sos,
    input logic edge_eos
);

    int unsigned fail_cnt = 0;   // Number of failed checks

    strobe_with_vld: assert property (@(posedge clk) disable iff (!reset)
        (!(sm_sos || sm_eos) || sm_vld) && (!(edge_sos || edge_eos) || edge_vld))
        else begin
            $error("sos or eos raised without its vld");
            fail_cnt++;
        end

    one_sink_at_a_time: assert property (@(posedge clk) disable iff (!reset)
        !(sm_vld && edge_vld))
        else begin
            $error("sm_vld and edge_vld high together");
            fail_cnt++;
        end

    // No gaps inside a stream or an edge read
    sm_no_gap: assert property (@(posedge clk) disable iff (!reset)
        sm_vld && !sm_eos |=> sm_vld)
        else begin
            $error("sm_vld dropped before sm_eos");
            fail_cnt++;
        end

    edge_no_gap: assert property (@(posedge clk) disable iff (!reset)
        edge_vld && !edge_eos |=> edge_vld)
        else begin
            $error("edge_vld dropped before edge_eos");
            fail_cnt++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        !reset |=> !(sm_vld || sm_sos || sm_eos || edge_vld || edge_sos || edge_eos))
        else begin
            $error("outputs active after reset");
            fail_cnt++;
        end

endmodule

bind fv_bank_cntl fv_mem_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .sm_vld   (sm_vld),
    .sm_sos   (sm_sos),
    .sm_eos   (sm_eos),
    .edge_vld (edge_vld),
    .edge_sos (edge_sos),
    .edge_eos (edge_eos)
);

/* src/fv_mem_top.sv */
`timescale 1ns/10ps

`include "fv_defs.svh"

module fv_mem_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`ITER_W-1:0]        replay_iter,
    input  logic                      update_phase,
    input  logic [`FV_NUM_W-1:0]      fv_num,
    input  logic                      req_valid,
    input  logic                      req_rd_wr,
    input  logic                      req_wr_eos,
    input  logic [`NODE_ID_W-1:0]     req_node_id,
    input  fv_pkg::fv_req_payload_u   req_payload,
    output logic                      sm_vld,
    output logic                      sm_sos,
    output logic                      sm_eos,
    output logic [`LINE_IDX_W-1:0]    sm_addr,
    output logic [`FV_WIDTH-1:0]      sm_data,
    output logic                      edge_vld,
    output logic                      edge_sos,
    output logic                      edge_eos,
    output logic [`PE_TAG_W-1:0]      edge_pe_tag,
    output logic [`FV_WIDTH-1:0]      edge_data
);

    logic                    sram_cen;
    logic                    sram_wen;
    logic [`SRAM_ADDR_W-1:0] sram_addr;
    logic [`FV_WIDTH-1:0]    sram_wdata;
    logic [`FV_WIDTH-1:0]    sram_rdata;

    fv_bank_cntl u_cntl (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_phase (update_phase),
        .fv_num       (fv_num),
        .req_valid    (req_valid),
        .req_rd_wr    (req_rd_wr),
        .req_wr_eos   (req_wr_eos),
        .req_node_id  (req_node_id),
        .req_payload  (req_payload),
        .sram_cen     (sram_cen),
        .sram_wen     (sram_wen),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_rdata   (sram_rdata),
        .sm_vld       (sm_vld),
        .sm_sos       (sm_sos),
        .sm_eos       (sm_eos),
        .sm_addr      (sm_addr),
        .sm_data      (sm_data),
        .edge_vld     (edge_vld),
        .edge_sos     (edge_sos),
        .edge_eos     (edge_eos),
        .edge_pe_tag  (edge_pe_tag),
        .edge_data    (edge_data)
    );

    fv_sram_bank u_sram (
        .clk   (clk),
        .cen   (sram_cen),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

/* src/fv_bank_cntl.sv */
`timescale 1ns/10ps

`include "fv_defs.svh"

module fv_bank_cntl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`ITER_W-1:0]        replay_iter,
    input  logic                      update_phase,
    input  logic [`FV_NUM_W-1:0]      fv_num,
    input  logic                      req_valid,
    input  logic                      req_rd_wr,
    input  logic                      req_wr_eos,
    input  logic [`NODE_ID_W-1:0]     req_node_id,
    input  fv_pkg::fv_req_payload_u   req_payload,
    output logic                      sram_cen,
    output logic                      sram_wen,
    output logic [`SRAM_ADDR_W-1:0]   sram_addr,
    output logic [`FV_WIDTH-1:0]      sram_wdata,
    input  logic [`FV_WIDTH-1:0]      sram_rdata,
    output logic                      sm_vld,
    output logic                      sm_sos,
    output logic                      sm_eos,
    output logic [`LINE_IDX_W-1:0]    sm_addr,
    output logic [`FV_WIDTH-1:0]      sm_data,
    output logic                      edge_vld,
    output logic                      edge_sos,
    output logic                      edge_eos,
    output logic [`PE_TAG_W-1:0]      edge_pe_tag,
    output logic [`FV_WIDTH-1:0]      edge_data
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_STREAM  = 2'd1;
    localparam logic [1:0] S_WB      = 2'd2;
    localparam logic [1:0] S_EDGE_RD = 2'd3;

    logic [1:0]                 state, nx_state;
    logic [`LINE_W-1:0]         line_cnt, nx_line_cnt;
    logic [`LOCAL_NODE_W-1:0]   node_cnt, nx_node_cnt;
    logic [`LINE_W:0]           num_lines, nx_num_lines;
    logic [`ITER_W-1:0]         cur_iter, nx_cur_iter;
    logic                       streamed, nx_streamed;
    logic [`NODE_ID_W-1:0]      node_q, nx_node_q;
    logic [`PE_TAG_W-1:0]       pe_tag_q, nx_pe_tag_q;

    logic line_last;
    logic node_last;
    logic stream_go;

    // Lines per node is half the feature count, rounded up
    function automatic logic [`LINE_W:0] line_count(input logic [`FV_NUM_W-1:0] num);
        logic [`FV_NUM_W:0] sum;
        sum = {1'b0, num} + 1'b1;
        return sum[`LINE_W+1:1];
    endfunction

    assign line_last = ({1'b0, line_cnt} + 1'b1) >= num_lines;
    assign node_last = node_cnt == (`NODES_PER_ITER - 1);
    assign stream_go = !update_phase && (!streamed || replay_iter != cur_iter);

    // Outputs carry the line read in the previous cycle
    assign sm_vld  = state == S_STREAM;
    assign sm_sos  = sm_vld && line_cnt == '0 && node_cnt == '0;
    assign sm_eos  = sm_vld && line_last && node_last;
    assign sm_addr = {node_cnt, line_cnt};
    assign sm_data = sram_rdata;

    assign edge_vld    = state == S_EDGE_RD;
    assign edge_sos    = edge_vld && line_cnt == '0;
    assign edge_eos    = edge_vld && line_last;
    assign edge_pe_tag = edge_vld ? pe_tag_q : '0;
    assign edge_data   = sram_rdata;

    always_comb begin
        nx_state     = state;
        nx_line_cnt  = line_cnt;
        nx_node_cnt  = node_cnt;
        nx_num_lines = num_lines;
        nx_cur_iter  = cur_iter;
        nx_streamed  = streamed;
        nx_node_q    = node_q;
        nx_pe_tag_q  = pe_tag_q;

        sram_cen   = 1'b1;
        sram_wen   = 1'b1;
        sram_addr  = '0;
        sram_wdata = '0;

        case (state)
            S_IDLE: begin
                if (stream_go) begin
                    nx_state     = S_STREAM;
                    nx_cur_iter  = replay_iter;
                    nx_streamed  = 1'b1;
                    nx_num_lines = line_count(fv_num);
                    nx_line_cnt  = '0;
                    nx_node_cnt  = '0;
                    sram_cen     = 1'b0;
                    sram_addr    = {replay_iter, {`LINE_IDX_W{1'b0}}};   // First line of node 0
                end else if (update_phase && req_valid) begin
                    nx_node_q = req_node_id;
                    sram_cen  = 1'b0;
                    sram_addr = {req_node_id, {`LINE_W{1'b0}}};
                    if (req_rd_wr) begin
                        // Line 0 of the burst commits now
                        sram_wen   = 1'b0;
                        sram_wdata = req_payload.data;
                        if (!req_wr_eos) begin
                            nx_state    = S_WB;
                            nx_line_cnt = 'd1;
                        end
                    end else begin
                        nx_state     = S_EDGE_RD;
                        nx_num_lines = line_count(req_payload.rd.fv_num);
                        nx_pe_tag_q  = req_payload.rd.pe_tag;
                        nx_line_cnt  = '0;
                    end
                end
            end

            S_STREAM: begin
                if (line_last) begin
                    nx_line_cnt = '0;
                    nx_node_cnt = node_cnt + 1'b1;
                end else begin
                    nx_line_cnt = line_cnt + 1'b1;
                end

                if (line_last && node_last) begin
                    nx_state    = S_IDLE;
                    nx_node_cnt = '0;
                end else begin
                    sram_cen  = 1'b0;                              // Prefetch next line
                    sram_addr = {cur_iter, nx_node_cnt, nx_line_cnt};
                end
            end

            S_WB: begin
                if (req_valid && req_rd_wr) begin
                    sram_cen    = 1'b0;
                    sram_wen    = 1'b0;
                    sram_addr   = {node_q, line_cnt};
                    sram_wdata  = req_payload.data;
                    nx_line_cnt = line_cnt + 1'b1;
                    if (req_wr_eos) begin
                        nx_state    = S_IDLE;
                        nx_line_cnt = '0;
                    end
                end
            end

            S_EDGE_RD: begin
                if (line_last) begin
                    nx_state    = S_IDLE;
                    nx_line_cnt = '0;
                end else begin
                    nx_line_cnt = line_cnt + 1'b1;
                    sram_cen    = 1'b0;
                    sram_addr   = {node_q, nx_line_cnt};
                end
            end

            default: nx_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= S_IDLE;
            line_cnt <= '0;
            node_cnt <= '0;
            cur_iter <= '0;
            streamed <= 1'b0;
        end else begin
            state    <= nx_state;
            line_cnt <= nx_line_cnt;
            node_cnt <= nx_node_cnt;
            cur_iter <= nx_cur_iter;
            streamed <= nx_streamed;
        end
    end

    // Captured request fields
    always_ff @(posedge clk) begin
        num_lines <= nx_num_lines;
        node_q    <= nx_node_q;
        pe_tag_q  <= nx_pe_tag_q;
    end

endmodule

/* src/fv_sram_bank.sv */
`timescale 1ns/10ps

`include "fv_defs.svh"

module fv_sram_bank (
    input  logic                    clk,
    input  logic                    cen,    // Active low
    input  logic                    wen,    // Active low
    input  logic [`SRAM_ADDR_W-1:0] addr,
    input  logic [`FV_WIDTH-1:0]    wdata,
    output logic [`FV_WIDTH-1:0]    rdata
);

    logic [`FV_WIDTH-1:0] mem [`SRAM_DEPTH];

    // Single port, one cycle read latency
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* src/fv_pkg.sv */
`include "fv_defs.svh"

package fv_pkg;

    // Request payload word
    // A write carries a full feature line, a read carries a small descriptor
    typedef union packed {
        logic [`FV_WIDTH-1:0] data;
        struct packed {
            logic [`FV_WIDTH-`PE_TAG_W-`FV_NUM_W-1:0] pad;  // Zero on a read
            logic [`PE_TAG_W-1:0]                     pe_tag;
            logic [`FV_NUM_W-1:0]                     fv_num;
        } rd;
    } fv_req_payload_u;

endpackage

/* src/fv_defs.svh */
`ifndef FV_DEFS_SVH
`define FV_DEFS_SVH

// Bank geometry
`define FV_WIDTH         64     // Two 32-bit feature values per line
`define LINES_PER_NODE   8
`define MAX_FV_NUM       16
`define NODES_PER_ITER   4
`define NUM_REPLAY_ITER  4
`define NUM_EDGE_PE      4

`define NUM_NODES        (`NODES_PER_ITER * `NUM_REPLAY_ITER)
`define SRAM_DEPTH       (`NUM_NODES * `LINES_PER_NODE)

// Derived widths
`define NODE_ID_W        ($clog2(`NUM_NODES))
`define SRAM_ADDR_W      ($clog2(`SRAM_DEPTH))
`define LINE_W           ($clog2(`LINES_PER_NODE))
`define LOCAL_NODE_W     ($clog2(`NODES_PER_ITER))
`define LINE_IDX_W       (`LOCAL_NODE_W + `LINE_W)
`define ITER_W           ($clog2(`NUM_REPLAY_ITER))
`define PE_TAG_W         ($clog2(`NUM_EDGE_PE))
`define FV_NUM_W         ($clog2(`MAX_FV_NUM) + 1)

`endif
